//--- Bender.yml
package:
  name: heapMemory

sources:
  - include_dirs:
      - sim
    files:
      - rtl/heapPkg.sv
      - rtl/arrayAllocator.sv
      - rtl/accessChecker.sv
      - rtl/elementAlu.sv
      - rtl/arrayStore.sv
      - rtl/heapMemory.sv
      - sim/heapMemoryTb.sv

//--- heapMemory.f
+incdir+sim
rtl/heapPkg.sv
rtl/arrayAllocator.sv
rtl/accessChecker.sv
rtl/elementAlu.sv
rtl/arrayStore.sv
rtl/heapMemory.sv
sim/heapMemoryTb.sv

//--- rtl/accessChecker.sv
/*
  Access checker
  Judges each request against allocation state and the array's size
*/
`timescale 1ns/10ps

module accessChecker
  import heapPkg::*;
(
  input  heapRequest            request,
  input  logic [arrayCount-1:0] allocated,                // Per-array in-use flags
  input  logic [addressBits:0]  freshCount,               // Arrays ever handed out
  input  arraySize              currentSize,              // Size of the addressed array
  output heapError              verdict
);

  heapError allocState;                                   // Result of the allocation rule
  logic     inBounds;                                     // Index below the size

  always_comb begin
    if ({1'b0, request.array} >= freshCount) begin
      allocState = notAllocated;                          // Never handed out
    end else if (!allocated[request.array]) begin
      allocState = freed;
    end else begin
      allocState = ok;
    end
  end

  assign inBounds = {1'b0, request.index} < currentSize;

  always_comb begin
    case (request.action)
      idle, clearAll, alloc:          verdict = ok;       // Always legal
      write, size, push, pop, free:   verdict = allocState;
      default:                                            // Read and element operations
        verdict = (allocState != ok) ? allocState : (inBounds ? ok : outOfBounds);
    endcase
  end

endmodule

//--- rtl/arrayAllocator.sv
/*
  Array allocator
  Tracks which arrays are in use, hands out fresh arrays in order and
  reuses freed arrays last in, first out
*/
`timescale 1ns/10ps

module arrayAllocator
  import heapPkg::*;
(
  input  logic                  clock,
  input  logic                  reset,
  input  heapRequest            request,
  input  heapError              verdict,                  // Free only acts on a legal request
  output logic [arrayCount-1:0] allocated,                // Set while an array is in use
  output logic [addressBits:0]  freshCount,               // Next never-used array number
  output arrayId                allocId,                  // Choice for an alloc this cycle
  output logic                  outOfMemory               // Every array is in use
);

  arrayId               freedStack [arrayCount];          // Freed array numbers
  logic [addressBits:0] stackDepth;                       // Entries on the freed stack
  arrayId               stackTop;                         // Slot of the newest entry
  logic                 takeAlloc;                        // Alloc served this cycle
  logic                 takeFree;                         // Free accepted this cycle

  // ------------------------------------------------------------
  // Choice of the next array
  // ------------------------------------------------------------
  assign stackTop    = arrayId'(stackDepth - 1'b1);
  assign outOfMemory = (stackDepth == '0) && (freshCount == arrayCount);

  always_comb begin
    if (stackDepth != '0) begin
      allocId = freedStack[stackTop];                     // Most recently freed first
    end else begin
      allocId = freshCount[addressBits-1:0];              // Else the next fresh one
    end
  end

  assign takeAlloc = (request.action == alloc) && !outOfMemory;
  assign takeFree  = (request.action == free) && (verdict == ok);

  // ------------------------------------------------------------
  // Flags and counters
  // ------------------------------------------------------------
  always_ff @(posedge clock) begin
    if (reset || request.action == clearAll) begin
      allocated  <= '0;                                   // Nothing in use
      freshCount <= '0;
      stackDepth <= '0;                                   // Freed stack forgotten
    end else if (takeAlloc) begin
      allocated[allocId] <= 1'b1;
      if (stackDepth != '0) begin
        stackDepth <= stackDepth - 1'b1;                  // Pop the reused number
      end else begin
        freshCount <= freshCount + 1'b1;
      end
    end else if (takeFree) begin
      allocated[request.array] <= 1'b0;
      stackDepth               <= stackDepth + 1'b1;
    end
  end

  // A freed array is never on the stack twice, so depth stays within arrayCount
  always_ff @(posedge clock) begin
    if (takeFree) begin
      freedStack[stackDepth[addressBits-1:0]] <= request.array;
    end
  end

endmodule

//--- rtl/arrayStore.sv
/*
  Array store
  Element memory and size table, with the registered result and status
*/
`timescale 1ns/10ps

module arrayStore
  import heapPkg::*;
(
  input  logic       clock,
  input  logic       reset,
  input  heapRequest request,
  input  heapError   verdict,                             // From the access checker
  input  arrayId     allocId,                             // Array an alloc takes
  input  logic       outOfMemory,                         // Alloc cannot be served
  input  dataWord    updated,                             // ALU write-back value
  input  dataWord    reported,                            // ALU value to return
  output dataWord    stored,                              // Addressed element
  output arraySize   currentSize,                         // Size of the addressed array
  output dataWord    result,
  output heapError   status
);

  dataWord     elements [arrayCount][arrayLength];        // All arrays in fixed blocks
  arraySize    sizes    [arrayCount];                     // Element count per array
  elementIndex readIndex;                                 // Top element for pop
  heapError    outcome;                                   // Verdict plus push and pop limits
  logic        hasValue;                                  // Request returns a value
  dataWord     value;                                     // Value to return

  // ------------------------------------------------------------
  // Read side
  // ------------------------------------------------------------
  assign currentSize = sizes[request.array];
  assign readIndex   = (request.action == pop) ? elementIndex'(currentSize - 1'b1)
                                               : request.index;
  assign stored      = elements[request.array][readIndex];

  always_comb begin
    outcome = verdict;
    if (verdict == ok) begin
      case (request.action)
        alloc: if (outOfMemory) outcome = heapPkg::outOfMemory;
        push:  if (currentSize == arrayLength) outcome = arrayFull;
        pop:   if (currentSize == '0) outcome = arrayEmpty;
        default: ;
      endcase
    end
  end

  always_comb begin
    hasValue = 1'b1;
    value    = reported;                                  // Element operations
    case (request.action)
      alloc:                   value = dataWord'(allocId);
      write:                   value = request.data;      // Echo the written word
      read, pop:               value = stored;
      size:                    value = dataWord'(currentSize);
      idle, clearAll, free, push: hasValue = 1'b0;
      default: ;
    endcase
  end

  // ------------------------------------------------------------
  // Memory and size updates
  // ------------------------------------------------------------
  always_ff @(posedge clock) begin
    if (outcome == ok) begin
      case (request.action)
        write: begin
          elements[request.array][request.index] <= request.data;
          if ({1'b0, request.index} >= currentSize) begin
            sizes[request.array] <= arraySize'(request.index) + 1'b1;  // Grow past the end
          end
        end
        push: begin
          elements[request.array][currentSize[indexBits-1:0]] <= request.data;
          sizes[request.array] <= currentSize + 1'b1;
        end
        pop:   sizes[request.array] <= currentSize - 1'b1;
        alloc: sizes[allocId] <= '0;                      // Fresh or reused, starts empty
        add, addAfter, subtract, subAfter, shiftLeft, shiftRight,
        bitNot, bitOr, bitXor, bitAnd:
          elements[request.array][request.index] <= updated;
        default: ;
      endcase
    end
  end

  // Response registers
  always_ff @(posedge clock) begin
    if (reset) begin
      status <= ok;
      result <= '0;
    end else if (request.action != idle) begin
      status <= outcome;
      if (outcome == ok && hasValue) begin
        result <= value;                                  // Failures keep the old result
      end
    end
  end

endmodule

//--- rtl/elementAlu.sv
/*
  Element ALU
  Read-modify-write arithmetic, shifts and bitwise logic on one element
*/
`timescale 1ns/10ps

module elementAlu
  import heapPkg::*;
(
  input  heapAction action,
  input  dataWord   stored,                               // Element before the operation
  input  dataWord   operand,                              // Request data word
  output dataWord   updated,                              // Value written back
  output dataWord   reported                              // Value returned to the requester
);

  logic reportOld;                                        // Return the value before the change

  always_comb begin
    case (action)
      add, addAfter:      updated = stored + operand;
      subtract, subAfter: updated = stored - operand;
      shiftLeft:          updated = stored << operand;    // Large shifts give zero
      shiftRight:         updated = stored >> operand;
      bitNot:             updated = ~stored;              // Operand unused
      bitOr:              updated = stored | operand;
      bitXor:             updated = stored ^ operand;
      bitAnd:             updated = stored & operand;
      default:            updated = stored;               // Not an element operation
    endcase
  end

  assign reportOld = (action == addAfter) || (action == subAfter);
  assign reported  = reportOld ? stored : updated;

endmodule

//--- rtl/heapMemory.sv
/*
  Array heap top level
  A pool of small arrays with allocation, element access and element arithmetic
*/
`timescale 1ns/10ps

module heapMemory
  import heapPkg::*;
(
  input  logic       clock,
  input  logic       reset,
  input  heapRequest request,                             // Sampled on every rising edge
  output dataWord    result,                              // Value of the last request that made one
  output heapError   status                               // Outcome of the last non-idle request
);

  heapError                 verdict;                      // Allocation and bounds check
  logic [arrayCount-1:0]    allocated;                    // One flag per array
  logic [addressBits:0]     freshCount;                   // Arrays ever handed out
  arrayId                   allocId;                      // Array an alloc would take
  logic                     memoryExhausted;              // Alloc cannot be served
  arraySize                 currentSize;                  // Size of the addressed array
  dataWord                  stored;                       // Addressed element
  dataWord                  updated;                      // ALU write-back value
  dataWord                  reported;                     // ALU value to return

  arrayAllocator arrayAllocator_inst (
    .clock       (clock),
    .reset       (reset),
    .request     (request),
    .verdict     (verdict),
    .allocated   (allocated),
    .freshCount  (freshCount),
    .allocId     (allocId),
    .outOfMemory (memoryExhausted)
  );

  accessChecker accessChecker_inst (
    .request     (request),
    .allocated   (allocated),
    .freshCount  (freshCount),
    .currentSize (currentSize),
    .verdict     (verdict)
  );

  elementAlu elementAlu_inst (
    .action   (request.action),
    .stored   (stored),
    .operand  (request.data),
    .updated  (updated),
    .reported (reported)
  );

  arrayStore arrayStore_inst (
    .clock       (clock),
    .reset       (reset),
    .request     (request),
    .verdict     (verdict),
    .allocId     (allocId),
    .outOfMemory (memoryExhausted),
    .updated     (updated),
    .reported    (reported),
    .stored      (stored),
    .currentSize (currentSize),
    .result      (result),
    .status      (status)
  );

endmodule

//--- rtl/heapPkg.sv
/*
  Array heap shared definitions
  Widths, vector types, action and error codes, and the request struct
*/
package heapPkg;

  // ------------------------------------------------------------
  // Widths
  // ------------------------------------------------------------
  localparam int addressBits = 4;                         // Bits in an array number
  localparam int indexBits   = 3;                         // Bits in an element index
  localparam int dataBits    = 16;                        // Bits in an element
  localparam int arrayCount  = 2 ** addressBits;          // Arrays in the pool
  localparam int arrayLength = 2 ** indexBits;            // Elements per array

  typedef logic [addressBits-1:0] arrayId;                // Array number
  typedef logic [indexBits-1:0]   elementIndex;           // Index within one array
  typedef logic [indexBits:0]     arraySize;              // Zero up to arrayLength
  typedef logic [dataBits-1:0]    dataWord;               // Element value

  // ------------------------------------------------------------
  // Request actions and error kinds
  // ------------------------------------------------------------
  typedef enum logic [7:0] {
    idle,                                                 // No request this cycle
    clearAll,                                             // Forget every array
    alloc,                                                // Hand out an empty array
    free,                                                 // Return an array for reuse
    write,
    read,
    size,                                                 // Report element count
    push,
    pop,
    add,
    addAfter,                                             // Reports value before the add
    subtract,
    subAfter,                                             // Reports value before the subtract
    shiftLeft,
    shiftRight,
    bitNot,
    bitOr,
    bitXor,
    bitAnd
  } heapAction;

  typedef enum logic [2:0] {
    ok,
    notAllocated,                                         // Never handed out
    freed,                                                // Handed out then freed
    outOfBounds,                                          // Index at or past the size
    arrayFull,
    arrayEmpty,
    outOfMemory                                           // No fresh or freed array left
  } heapError;

  typedef struct packed {
    heapAction   action;
    arrayId      array;
    elementIndex index;
    dataWord     data;                                    // Write value or operand
  } heapRequest;

endpackage

//--- sim/heapModel.svh
/*
  Array heap reference model
  Allocation flags, freed stack, sizes and element contents kept in step with requests
*/
`ifndef HEAP_MODEL_SVH
`define HEAP_MODEL_SVH

bit      modelAllocated [arrayCount];                     // Array in use
int      modelFresh;                                      // Arrays ever handed out
arrayId  modelFreed [$];                                  // Newest freed number at the back
int      modelSizes [arrayCount];                         // Element count per array
dataWord modelElements [arrayCount][arrayLength];
dataWord modelResult;                                     // Last value returned

task automatic clearModel();
  modelAllocated = '{default: 1'b0};
  modelFresh     = 0;
  modelFreed.delete();                                    // Freed numbers forgotten too
endtask

function automatic dataWord operate(heapAction action, dataWord old, dataWord operand);
  case (action)
    add, addAfter:      return old + operand;
    subtract, subAfter: return old - operand;
    shiftLeft:          return old << operand;            // Zero once past the width
    shiftRight:         return old >> operand;
    bitNot:             return ~old;
    bitOr:              return old | operand;
    bitXor:             return old ^ operand;
    default:            return old & operand;             // bitAnd
  endcase
endfunction

task automatic applyToModel(input heapRequest req, output heapError expected);
  heapError state;
  dataWord  old;
  dataWord  fresh;
  int       count;
  state = (req.array >= modelFresh) ? notAllocated : (modelAllocated[req.array] ? ok : freed);
  count = modelSizes[req.array];
  old   = modelElements[req.array][req.index];
  if (req.action inside {read, add, addAfter, subtract, subAfter, shiftLeft, shiftRight,
                         bitNot, bitOr, bitXor, bitAnd} && state == ok && req.index >= count)
    state = outOfBounds;                                  // Bounds only after allocation
  if (req.action inside {clearAll, alloc})
    state = ok;
  if (state == ok) begin
    case (req.action)
      clearAll: clearModel();
      alloc: begin
        if (modelFreed.size() != 0) begin
          modelResult = dataWord'(modelFreed.pop_back());  // Reuse newest freed
        end else if (modelFresh < arrayCount) begin
          modelResult = dataWord'(modelFresh);
          modelFresh++;
        end else begin
          state = outOfMemory;
        end
        if (state == ok) begin
          modelAllocated[modelResult[addressBits-1:0]] = 1'b1;
          modelSizes[modelResult[addressBits-1:0]]     = 0;  // Starts empty
        end
      end
      free: begin
        modelAllocated[req.array] = 1'b0;
        modelFreed.push_back(req.array);
      end
      write: begin
        modelElements[req.array][req.index] = req.data;
        modelResult = req.data;
        if (req.index >= count)
          modelSizes[req.array] = req.index + 1;          // Grows past the end
      end
      read: modelResult = old;
      size: modelResult = dataWord'(count);
      push: begin
        if (count == arrayLength) begin
          state = arrayFull;
        end else begin
          modelElements[req.array][count] = req.data;
          modelSizes[req.array] = count + 1;
        end
      end
      pop: begin
        if (count == 0) begin
          state = arrayEmpty;
        end else begin
          modelSizes[req.array] = count - 1;
          modelResult = modelElements[req.array][count-1];  // Top element
        end
      end
      default: begin
        fresh = operate(req.action, old, req.data);
        modelElements[req.array][req.index] = fresh;
        modelResult = (req.action inside {addAfter, subAfter}) ? old : fresh;
      end
    endcase
  end
  expected = state;
endtask

`endif

//--- sim/heapMemoryTb.sv
/*
  Array heap testbench
  Runs allocation, access, stack and arithmetic sequences against a reference model
*/
`timescale 1ns/10ps

module heapMemoryTb
  import heapPkg::*;
();

  localparam int clockPeriod = 100;                       // ns
  localparam int resetCycles = 4;
  localparam int waitLimit   = 20;                        // Cycles allowed for any wait
  localparam int seed        = 11;

  logic       clock;
  logic       reset;
  heapRequest request;
  dataWord    result;
  heapError   status;

  logic       checkNow;                                   // Request driven this cycle
  logic       checkQ;                                     // Its response is due now
  heapError   expStatusNow;
  heapError   expStatusQ;
  dataWord    expResultNow;
  dataWord    expResultQ;

  `include "heapModel.svh"

  heapMemory heapMemory_inst (
    .clock   (clock),
    .reset   (reset),
    .request (request),
    .result  (result),
    .status  (status)
  );

  initial begin
    clock = 1'b0;
    forever #(clockPeriod / 2) clock = ~clock;
  end

  // ------------------------------------------------------------
  // Response checks
  // ------------------------------------------------------------
  always @(posedge clock) begin
    checkQ     <= checkNow;                               // Lines up with the DUT latency
    expStatusQ <= expStatusNow;
    expResultQ <= expResultNow;
  end

  statusMatches: assert property (@(posedge clock) disable iff (reset)
      checkQ |-> status == expStatusQ)
    else begin
      $display("Mismatch at %0t: status expected %0d got %0d", $time,
               $sampled(expStatusQ), $sampled(status));
      $display("Result: FAILED");
      $fatal(1, "Status check stopped the run");
    end

  resultMatches: assert property (@(posedge clock) disable iff (reset)
      checkQ |-> result == expResultQ)
    else begin
      $display("Mismatch at %0t: result expected %0h got %0h", $time,
               $sampled(expResultQ), $sampled(result));
      $display("Result: FAILED");
      $fatal(1, "Result check stopped the run");
    end

  // ------------------------------------------------------------
  // Stimulus
  // ------------------------------------------------------------
  task automatic sendRequest(input heapAction action, input arrayId array,
                             input elementIndex index, input dataWord data);
    heapRequest item;
    heapError   expected;
    item = '{action: action, array: array, index: index, data: data};
    applyToModel(item, expected);                         // Model sees it first
    @(posedge clock);
    request      <= item;
    checkNow     <= 1'b1;
    expStatusNow <= expected;
    expResultNow <= modelResult;
  endtask

  task automatic waitForChecks();
    int waited;
    waited = 0;
    @(posedge clock);
    request  <= '0;                                       // Idle action
    checkNow <= 1'b0;
    while (checkNow || checkQ) begin
      if (waited == waitLimit) begin
        $display("Responses still pending after %0d cycles", waitLimit);
        $display("Result: FAILED");
        $fatal(1, "Drain timeout");
      end else begin
        @(posedge clock);
        waited++;
      end
    end
  endtask

  initial begin
    int        waited;
    int        i;
    dataWord   operand;
    heapAction operations [10];
    void'($urandom(seed));
    reset        = 1'b1;
    request      = '0;
    checkNow     = 1'b0;
    expStatusNow = ok;
    expResultNow = '0;
    clearModel();
    modelResult  = '0;                                    // Reset value of result
    operations   = '{add, addAfter, subtract, subAfter, shiftLeft, shiftRight,
                     bitNot, bitOr, bitXor, bitAnd};
    repeat (resetCycles) @(posedge clock);
    reset  <= 1'b0;
    waited = 0;
    while (reset !== 1'b0) begin
      if (waited == waitLimit) begin
        $display("Reset was not released within %0d cycles", waitLimit);
        $display("Result: FAILED");
        $fatal(1, "Reset timeout");
      end else begin
        @(posedge clock);
        waited++;
      end
    end

    // Read before any alloc leaves the reset result
    sendRequest(read, '0, '0, '0);

    // Fresh arrays in order, then one alloc too many
    for (i = 0; i <= arrayCount; i++)
      sendRequest(alloc, '0, '0, '0);

    // Freed arrays come back newest first
    sendRequest(free, 4'd5, '0, '0);
    sendRequest(free, 4'd9, '0, '0);
    sendRequest(alloc, '0, '0, '0);
    sendRequest(write, 4'd5, '0, dataWord'($urandom));    // Still freed
    sendRequest(clearAll, '0, '0, '0);
    sendRequest(alloc, '0, '0, '0);                       // Array zero again
    sendRequest(write, 4'd7, '0, dataWord'($urandom));    // Never handed out

    // Writes, reads and bounds on array zero
    for (i = 5; i >= 0; i--)
      sendRequest(write, '0, elementIndex'(i), dataWord'($urandom));  // First lands past the end
    for (i = 0; i < 10; i++)
      sendRequest(write, '0, elementIndex'($urandom % 6), dataWord'($urandom));
    for (i = 0; i < arrayLength; i++)
      sendRequest(read, '0, elementIndex'(i), '0);       // Last two out of bounds
    sendRequest(size, '0, '0, '0);

    // Stack use of array one
    sendRequest(alloc, '0, '0, '0);
    for (i = 0; i <= arrayLength; i++)
      sendRequest(push, 4'd1, '0, dataWord'($urandom));  // Last push hits full
    for (i = 0; i <= arrayLength; i++)
      sendRequest(pop, 4'd1, '0, '0);                     // Last pop hits empty

    // Each element operation twice
    for (i = 0; i < 20; i++) begin
      if (operations[i % 10] inside {shiftLeft, shiftRight})
        operand = dataWord'($urandom % 20);               // Mostly in range
      else
        operand = dataWord'($urandom);
      sendRequest(operations[i % 10], '0, elementIndex'($urandom % 6), operand);
    end
    sendRequest(add, '0, 3'd7, dataWord'($urandom));      // Beyond the size

    // clearAll forgets every array
    sendRequest(clearAll, '0, '0, '0);
    for (i = 0; i < arrayCount; i++)
      sendRequest(size, arrayId'(i), '0, '0);
    sendRequest(alloc, '0, '0, '0);

    waitForChecks();
    $display("Result: PASSED");
    $finish;
  end

endmodule
